/* src/regread_pkg.sv */
package regread_pkg;

    // register file geometry
    localparam int NUM_PR         = 64;
    localparam int NUM_WB         = 6;
    localparam int NUM_RD_SLOTS   = 8;
    localparam int NUM_BANKS      = 4;

    // two read ports per bank, one bank port left free beside a write
    localparam int NUM_BANK_PORTS = 8;
    localparam int MIXED_READS    = 4;

    typedef logic [31:0]                       word_t;
    typedef logic [$clog2(NUM_PR)-1:0]         preg_t;
    typedef logic [$clog2(NUM_WB)-1:0]         wb_id_t;
    typedef logic [$clog2(NUM_RD_SLOTS)-1:0]   slot_id_t;

    // how the bank ports are split in one service cycle
    typedef enum logic [1:0] {
        MODE_WRITE2,
        MODE_MIXED,
        MODE_READ8
    } port_mode_e;

endpackage

/* src/bank_port_if.sv */
interface bank_port_if;
    import regread_pkg::*;

    // lane 0 drives port A of every bank, lane 1 drives port B
    logic [1:0]                     wr_en;
    preg_t [1:0]                    wr_addr;
    word_t [1:0]                    wr_data;

    // position p reads bank p mod 4, positions 4..7 sit on port B
    logic [NUM_BANK_PORTS-1:0]      rd_en;
    preg_t [NUM_BANK_PORTS-1:0]     rd_addr;
    slot_id_t [NUM_BANK_PORTS-1:0]  rd_slot;

    // final service cycle of a batch with reads
    logic                           last;

    modport sched (
        output wr_en, wr_addr, wr_data,
        output rd_en, rd_addr, rd_slot,
        output last
    );

    modport rf (
        input wr_en, wr_addr, wr_data,
        input rd_en, rd_addr, rd_slot,
        input last
    );

endinterface

/* src/port_picker.sv */
module port_picker #(
    parameter int WIDTH = 8,
    parameter int PICKS = 8
) (
    input  logic [WIDTH-1:0]                     i_pending,
    output logic [PICKS-1:0]                     o_pick_valid,
    output logic [PICKS-1:0][$clog2(WIDTH)-1:0]  o_pick_id
);

    localparam int IDW = $clog2(WIDTH);

    // walk the request bits upward, filling pick slots in order
    always_comb begin
        int count;

        o_pick_valid = '0;
        o_pick_id    = '0;
        count        = 0;

        for (int i = 0; i < WIDTH; i++) begin
            if (i_pending[i] && (count < PICKS)) begin
                o_pick_valid[count] = 1'b1;
                o_pick_id[count]    = IDW'(i);
                count               = count + 1;
            end
        end
    end

endmodule

/* src/port_scheduler.sv */
module port_scheduler (
    input  logic                                               clk,
    input  logic                                               reset,
    input  logic                                               i_stall,
    input  logic [regread_pkg::NUM_WB-1:0]                     i_wb_valid,
    input  regread_pkg::preg_t [regread_pkg::NUM_WB-1:0]       i_wb_rd,
    input  regread_pkg::word_t [regread_pkg::NUM_WB-1:0]       i_wb_data,
    input  logic [regread_pkg::NUM_RD_SLOTS-1:0]               i_rd_valid,
    input  regread_pkg::preg_t [regread_pkg::NUM_RD_SLOTS-1:0] i_rd_addr,
    output logic                                               o_ready,
    bank_port_if.sched                                         port
);
    import regread_pkg::*;

    // batch state
    logic                       first_cycle;
    logic [NUM_WB-1:0]          wb_done;
    logic [NUM_RD_SLOTS-1:0]    rd_done;

    logic [NUM_WB-1:0]          wb_pending;
    logic [NUM_RD_SLOTS-1:0]    rd_pending;
    int unsigned                wb_cnt;
    int unsigned                rd_cnt;

    logic [1:0]                     wb_pick_valid;
    wb_id_t [1:0]                   wb_pick_id;
    logic [NUM_BANK_PORTS-1:0]      rd_pick_valid;
    slot_id_t [NUM_BANK_PORTS-1:0]  rd_pick_id;

    port_mode_e                 mode;
    logic                       last_cycle;
    logic                       hold;
    logic [NUM_WB-1:0]          wb_served;
    logic [NUM_RD_SLOTS-1:0]    rd_served;

    // nothing is done yet in the first cycle of a batch
    assign wb_pending = first_cycle ? i_wb_valid : (i_wb_valid & ~wb_done);
    assign rd_pending = first_cycle ? i_rd_valid : (i_rd_valid & ~rd_done);
    assign wb_cnt     = $countones(wb_pending);
    assign rd_cnt     = $countones(rd_pending);

    // no commands during reset or stall
    assign hold = i_stall || reset;

    port_picker #(
        .WIDTH (NUM_WB),
        .PICKS (2)
    ) u_wb_picker (
        .i_pending    (wb_pending),
        .o_pick_valid (wb_pick_valid),
        .o_pick_id    (wb_pick_id)
    );

    port_picker #(
        .WIDTH (NUM_RD_SLOTS),
        .PICKS (NUM_BANK_PORTS)
    ) u_rd_picker (
        .i_pending    (rd_pending),
        .o_pick_valid (rd_pick_valid),
        .o_pick_id    (rd_pick_id)
    );

    // writes first, a lone write shares the cycle with port B reads
    always_comb begin
        if (wb_cnt >= 2) begin
            mode       = MODE_WRITE2;
            last_cycle = (wb_cnt == 2) && (rd_cnt == 0);
        end else if (wb_cnt == 1) begin
            mode       = MODE_MIXED;
            last_cycle = (rd_cnt <= MIXED_READS);
        end else begin
            mode       = MODE_READ8;
            last_cycle = (rd_cnt <= NUM_BANK_PORTS);
        end
    end

    always_comb begin
        port.wr_en   = '0;
        port.wr_addr = '0;
        port.wr_data = '0;
        port.rd_en   = '0;
        port.rd_addr = '0;
        port.rd_slot = '0;
        port.last    = 1'b0;
        wb_served    = '0;
        rd_served    = '0;

        if (!hold) begin
            case (mode)
                MODE_WRITE2: begin
                    for (int l = 0; l < 2; l++) begin
                        port.wr_en[l]   = wb_pick_valid[l];
                        port.wr_addr[l] = i_wb_rd[wb_pick_id[l]];
                        port.wr_data[l] = i_wb_data[wb_pick_id[l]];
                        wb_served[wb_pick_id[l]] = wb_pick_valid[l];
                    end
                end
                MODE_MIXED: begin
                    port.wr_en[0]   = wb_pick_valid[0];
                    port.wr_addr[0] = i_wb_rd[wb_pick_id[0]];
                    port.wr_data[0] = i_wb_data[wb_pick_id[0]];
                    wb_served[wb_pick_id[0]] = wb_pick_valid[0];
                    // port A is busy with the write
                    for (int r = 0; r < MIXED_READS; r++) begin
                        port.rd_en[NUM_BANKS + r]   = rd_pick_valid[r];
                        port.rd_addr[NUM_BANKS + r] = i_rd_addr[rd_pick_id[r]];
                        port.rd_slot[NUM_BANKS + r] = rd_pick_id[r];
                        rd_served[rd_pick_id[r]]    = rd_pick_valid[r];
                    end
                end
                default: begin
                    for (int r = 0; r < NUM_BANK_PORTS; r++) begin
                        port.rd_en[r]            = rd_pick_valid[r];
                        port.rd_addr[r]          = i_rd_addr[rd_pick_id[r]];
                        port.rd_slot[r]          = rd_pick_id[r];
                        rd_served[rd_pick_id[r]] = rd_pick_valid[r];
                    end
                end
            endcase
            // inputs are stable across the batch, so any valid read counts
            port.last = last_cycle && (|i_rd_valid);
        end
    end

    assign o_ready = last_cycle && !hold;

    always_ff @(posedge clk) begin
        if (reset) begin
            first_cycle <= 1'b1;
            wb_done     <= '0;
            rd_done     <= '0;
        end else begin
            if (!hold) begin
                if (last_cycle) begin
                    // stale masks are ignored while first_cycle is set
                    first_cycle <= 1'b1;
                end else begin
                    first_cycle <= 1'b0;
                    wb_done     <= (first_cycle ? '0 : wb_done) | wb_served;
                    rd_done     <= (first_cycle ? '0 : rd_done) | rd_served;
                end
            end
        end
    end

endmodule

/* src/banked_reg_file.sv */
module banked_reg_file (
    input  logic                                                   clk,
    bank_port_if.rf                                                port,
    output logic [regread_pkg::NUM_BANK_PORTS-1:0]                 o_rd_valid,
    output regread_pkg::word_t [regread_pkg::NUM_BANK_PORTS-1:0]   o_rd_data,
    output regread_pkg::slot_id_t [regread_pkg::NUM_BANK_PORTS-1:0] o_rd_slot,
    output logic                                                   o_last
);
    import regread_pkg::*;

    // each bank is a true dual-port RAM holding a full copy of the file
    for (genvar b = 0; b < NUM_BANKS; b++) begin : g_bank
        word_t mem [NUM_PR];
        word_t dout_a;
        word_t dout_b;

        // port A, read-first
        always @(posedge clk) begin
            if (port.wr_en[0]) begin
                mem[port.wr_addr[0]] <= port.wr_data[0];
            end
            if (port.rd_en[b]) begin
                dout_a <= mem[port.rd_addr[b]];
            end
        end

        // port B, read-first
        always @(posedge clk) begin
            if (port.wr_en[1]) begin
                mem[port.wr_addr[1]] <= port.wr_data[1];
            end
            if (port.rd_en[b + NUM_BANKS]) begin
                dout_b <= mem[port.rd_addr[b + NUM_BANKS]];
            end
        end

        assign o_rd_data[b]             = dout_a;
        assign o_rd_data[b + NUM_BANKS] = dout_b;
    end

    // tags travel alongside the RAM latency
    always_ff @(posedge clk) begin
        o_rd_valid <= port.rd_en;
        o_rd_slot  <= port.rd_slot;
        o_last     <= port.last;
    end

endmodule

/* src/read_collector.sv */
module read_collector (
    input  logic                                                     clk,
    input  logic                                                     reset,
    input  logic [regread_pkg::NUM_BANK_PORTS-1:0]                   i_rd_valid,
    input  regread_pkg::word_t [regread_pkg::NUM_BANK_PORTS-1:0]     i_rd_data,
    input  regread_pkg::slot_id_t [regread_pkg::NUM_BANK_PORTS-1:0]  i_rd_slot,
    input  logic                                                     i_last,
    output regread_pkg::word_t [regread_pkg::NUM_RD_SLOTS-1:0]       o_read_data,
    output logic                                                     o_read_done
);
    import regread_pkg::*;

    // each returned word lands in the slot named by its tag
    always_ff @(posedge clk) begin
        for (int p = 0; p < NUM_BANK_PORTS; p++) begin
            if (i_rd_valid[p]) begin
                o_read_data[i_rd_slot[p]] <= i_rd_data[p];
            end
        end
    end

    // all reads of the batch are in the result registers this cycle
    always_ff @(posedge clk) begin
        if (reset) begin
            o_read_done <= 1'b0;
        end else begin
            o_read_done <= i_last;
        end
    end

endmodule

/* src/reg_read_stage.sv */
module reg_read_stage (
    input  logic                                               clk,
    input  logic                                               reset,
    input  logic                                               i_stall,
    input  logic [regread_pkg::NUM_WB-1:0]                     i_wb_valid,
    input  regread_pkg::preg_t [regread_pkg::NUM_WB-1:0]       i_wb_rd,
    input  regread_pkg::word_t [regread_pkg::NUM_WB-1:0]       i_wb_data,
    input  logic [regread_pkg::NUM_RD_SLOTS-1:0]               i_rd_valid,
    input  regread_pkg::preg_t [regread_pkg::NUM_RD_SLOTS-1:0] i_rd_addr,
    output logic                                               o_ready,
    output regread_pkg::word_t [regread_pkg::NUM_RD_SLOTS-1:0] o_read_data,
    output logic                                               o_read_done
);
    import regread_pkg::*;

    bank_port_if port ();

    // register file outputs, one cycle after the command
    logic [NUM_BANK_PORTS-1:0]      rf_rd_valid;
    word_t [NUM_BANK_PORTS-1:0]     rf_rd_data;
    slot_id_t [NUM_BANK_PORTS-1:0]  rf_rd_slot;
    logic                           rf_last;

    port_scheduler u_scheduler (
        .clk        (clk),
        .reset      (reset),
        .i_stall    (i_stall),
        .i_wb_valid (i_wb_valid),
        .i_wb_rd    (i_wb_rd),
        .i_wb_data  (i_wb_data),
        .i_rd_valid (i_rd_valid),
        .i_rd_addr  (i_rd_addr),
        .o_ready    (o_ready),
        .port       (port.sched)
    );

    banked_reg_file u_reg_file (
        .clk        (clk),
        .port       (port.rf),
        .o_rd_valid (rf_rd_valid),
        .o_rd_data  (rf_rd_data),
        .o_rd_slot  (rf_rd_slot),
        .o_last     (rf_last)
    );

    read_collector u_collector (
        .clk         (clk),
        .reset       (reset),
        .i_rd_valid  (rf_rd_valid),
        .i_rd_data   (rf_rd_data),
        .i_rd_slot   (rf_rd_slot),
        .i_last      (rf_last),
        .o_read_data (o_read_data),
        .o_read_done (o_read_done)
    );

endmodule

/* include/tb_tasks.svh */
// batch being prepared by a test, applied at the drive point
logic [NUM_WB-1:0]          stage_wb_valid;
preg_t [NUM_WB-1:0]         stage_wb_rd;
word_t [NUM_WB-1:0]         stage_wb_data;
logic [NUM_RD_SLOTS-1:0]    stage_rd_valid;
preg_t [NUM_RD_SLOTS-1:0]   stage_rd_addr;

// model of the register file and of the result slots
word_t                      model_reg [NUM_PR];
word_t                      exp_slot [NUM_RD_SLOTS];
logic [NUM_RD_SLOTS-1:0]    exp_known;
int                         next_free_reg;
int                         written_regs;

logic [31:0]                rng_state;
int                         wait_limit;
int                         check_count;
int                         error_count;

function automatic logic [31:0] next_rand();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
endfunction

// only registers written by earlier batches are read
function automatic preg_t random_known_reg();
    return preg_t'(next_rand() % written_regs);
endfunction

// two writes, else a lone write beside four reads, else eight reads
function automatic int expected_cycles(input int writes, input int reads);
    int w;
    int r;
    int n;
    w = writes;
    r = reads;
    n = 0;
    do begin
        if (w >= 2) begin
            w = w - 2;
        end else if (w == 1) begin
            w = 0;
            r = (r > 4) ? r - 4 : 0;
        end else begin
            r = (r > 8) ? r - 8 : 0;
        end
        n = n + 1;
    end while ((w > 0) || (r > 0));
    return n;
endfunction

task automatic report_mismatch(input string msg);
    error_count++;
    $display("FAILED at time %0t: %s", $time, msg);
endtask

task automatic report_timeout(input string what);
    error_count++;
    $display("timeout at time %0t while waiting for %s", $time, what);
endtask

task automatic clear_batch();
    stage_wb_valid = '0;
    stage_wb_rd    = '0;
    stage_wb_data  = '0;
    stage_rd_valid = '0;
    stage_rd_addr  = '0;
endtask

task automatic add_new_write(input int idx);
    stage_wb_valid[idx] = 1'b1;
    stage_wb_rd[idx]    = preg_t'(next_free_reg);
    stage_wb_data[idx]  = next_rand();
    next_free_reg++;
endtask

task automatic add_read(input int slot, input preg_t addr);
    stage_rd_valid[slot] = 1'b1;
    stage_rd_addr[slot]  = addr;
endtask

task automatic apply_batch();
    i_wb_valid = stage_wb_valid;
    i_wb_rd    = stage_wb_rd;
    i_wb_data  = stage_wb_data;
    i_rd_valid = stage_rd_valid;
    i_rd_addr  = stage_rd_addr;
endtask

task automatic drive_idle();
    clear_batch();
    apply_batch();
    i_stall = 1'b0;
endtask

task automatic check_results();
    for (int s = 0; s < NUM_RD_SLOTS; s++) begin
        if (exp_known[s]) begin
            check_count++;
            if (o_read_data[s] !== exp_slot[s]) begin
                report_mismatch($sformatf("slot %0d read %h, expected %h",
                                          s, o_read_data[s], exp_slot[s]));
            end
        end
    end
endtask

// drives the staged batch, stalled for its first stall_cycles cycles
task automatic run_batch(input int stall_cycles);
    int expected;
    int cycles;
    int waited;
    bit ready_seen;
    bit done_seen;
    bit has_reads;

    expected   = expected_cycles($countones(stage_wb_valid), $countones(stage_rd_valid))
                 + stall_cycles;
    has_reads  = |stage_rd_valid;
    ready_seen = 1'b0;
    done_seen  = 1'b0;

    @(posedge clk);
    #10;
    apply_batch();
    for (cycles = 1; cycles <= expected + wait_limit; cycles++) begin
        i_stall = (cycles <= stall_cycles);
        @(negedge clk);
        check_count++;
        if (o_ready && i_stall) begin
            report_mismatch("o_ready high during a stalled cycle");
        end
        if (o_read_done !== 1'b0) begin
            report_mismatch("o_read_done high before the batch was ready");
        end
        if (o_ready) begin
            ready_seen = 1'b1;
            break;
        end
        @(posedge clk);
        #10;
    end
    if (!ready_seen) begin
        report_timeout("o_ready");
    end else begin
        check_count++;
        if (cycles != expected) begin
            report_mismatch($sformatf("batch took %0d cycles, expected %0d", cycles, expected));
        end
    end

    // reads see the file as it was before this batch's writes
    for (int s = 0; s < NUM_RD_SLOTS; s++) begin
        if (stage_rd_valid[s]) begin
            exp_slot[s]  = model_reg[stage_rd_addr[s]];
            exp_known[s] = 1'b1;
        end
    end
    for (int i = 0; i < NUM_WB; i++) begin
        if (stage_wb_valid[i]) begin
            model_reg[stage_wb_rd[i]] = stage_wb_data[i];
        end
    end
    written_regs = next_free_reg;

    @(posedge clk);
    #10;
    drive_idle();

    if (has_reads) begin
        for (waited = 1; waited <= wait_limit; waited++) begin
            @(negedge clk);
            if (o_read_done) begin
                done_seen = 1'b1;
                break;
            end
        end
        if (!done_seen) begin
            report_timeout("o_read_done");
        end else begin
            check_count++;
            if (waited != 2) begin
                report_mismatch($sformatf("o_read_done %0d cycles after ready, expected 2",
                                          waited));
            end
            check_results();
            @(negedge clk);
            check_count++;
            if (o_read_done !== 1'b0) begin
                report_mismatch("o_read_done high for more than one cycle");
            end
        end
    end else begin
        for (int i = 0; i < 3; i++) begin
            @(negedge clk);
            check_count++;
            if (o_read_done !== 1'b0) begin
                report_mismatch("o_read_done pulsed for a batch without reads");
            end
        end
    end
endtask

/* tests/tb_reg_read_stage.sv */
module tb_reg_read_stage;
    import regread_pkg::*;

    logic                       clk;
    logic                       reset;
    logic                       i_stall;
    logic [NUM_WB-1:0]          i_wb_valid;
    preg_t [NUM_WB-1:0]         i_wb_rd;
    word_t [NUM_WB-1:0]         i_wb_data;
    logic [NUM_RD_SLOTS-1:0]    i_rd_valid;
    preg_t [NUM_RD_SLOTS-1:0]   i_rd_addr;
    logic                       o_ready;
    word_t [NUM_RD_SLOTS-1:0]   o_read_data;
    logic                       o_read_done;

    `include "tb_tasks.svh"

    reg_read_stage u_dut (
        .clk         (clk),
        .reset       (reset),
        .i_stall     (i_stall),
        .i_wb_valid  (i_wb_valid),
        .i_wb_rd     (i_wb_rd),
        .i_wb_data   (i_wb_data),
        .i_rd_valid  (i_rd_valid),
        .i_rd_addr   (i_rd_addr),
        .o_ready     (o_ready),
        .o_read_data (o_read_data),
        .o_read_done (o_read_done)
    );

    always #50 clk = ~clk;

    task automatic check_reset();
        int waited;
        bit ready_seen;
        ready_seen = 1'b0;
        for (int i = 0; i < 2; i++) begin
            @(negedge clk);
            check_count++;
            if ((o_ready !== 1'b0) || (o_read_done !== 1'b0)) begin
                report_mismatch("o_ready or o_read_done not low during reset");
            end
        end
        @(posedge clk);
        #10;
        reset = 1'b0;
        for (waited = 1; waited <= wait_limit; waited++) begin
            @(negedge clk);
            if (o_ready) begin
                ready_seen = 1'b1;
                break;
            end
        end
        if (!ready_seen) begin
            report_timeout("o_ready after reset");
        end else begin
            check_count++;
            if (waited != 1) begin
                report_mismatch($sformatf("o_ready rose %0d cycles after reset, expected 1",
                                          waited));
            end
        end
    endtask

    task automatic write_and_read_back();
        for (int b = 0; b < 6; b++) begin
            clear_batch();
            for (int i = 0; i < NUM_WB; i++) begin
                add_new_write(i);
            end
            run_batch(0);
        end
        clear_batch();
        add_new_write(0);
        add_new_write(3);
        run_batch(0);
        clear_batch();
        add_new_write(5);
        run_batch(0);
        clear_batch();
        for (int s = 0; s < NUM_RD_SLOTS; s++) begin
            add_read(s, random_known_reg());
        end
        run_batch(0);
    endtask

    task automatic mixed_batches();
        // one write with six reads, a mixed cycle then a read cycle
        clear_batch();
        for (int s = 0; s < 6; s++) begin
            add_read(s, random_known_reg());
        end
        add_new_write(2);
        run_batch(0);
        clear_batch();
        for (int s = 3; s < NUM_RD_SLOTS; s++) begin
            add_read(s, random_known_reg());
        end
        for (int i = 0; i < 3; i++) begin
            add_new_write(i * 2);
        end
        run_batch(0);
    endtask

    task automatic partial_and_empty();
        clear_batch();
        add_read(1, random_known_reg());
        add_read(4, random_known_reg());
        add_read(6, random_known_reg());
        run_batch(0);
        // slots 1, 4 and 6 have to keep their values
        clear_batch();
        add_read(0, random_known_reg());
        add_read(7, random_known_reg());
        run_batch(0);
        clear_batch();
        run_batch(0);
    endtask

    task automatic stalled_batches();
        clear_batch();
        for (int s = 0; s < NUM_RD_SLOTS; s++) begin
            add_read(s, random_known_reg());
        end
        run_batch(2);
        clear_batch();
        for (int s = 0; s < 4; s++) begin
            add_read(s * 2, random_known_reg());
        end
        add_new_write(1);
        run_batch(3);
    endtask

    // one batch per cycle, each pulse two cycles behind its batch
    task automatic back_to_back_reads();
        word_t batch_data [4][NUM_RD_SLOTS];
        preg_t addr;
        for (int c = 0; c < $size(batch_data) + 2; c++) begin
            @(posedge clk);
            #10;
            if (c < $size(batch_data)) begin
                clear_batch();
                for (int s = 0; s < NUM_RD_SLOTS; s++) begin
                    addr = random_known_reg();
                    add_read(s, addr);
                    batch_data[c][s] = model_reg[addr];
                end
                apply_batch();
            end else begin
                drive_idle();
            end
            @(negedge clk);
            if (c < $size(batch_data)) begin
                check_count++;
                if (o_ready !== 1'b1) begin
                    report_mismatch($sformatf("o_ready low for back-to-back batch %0d", c));
                end
            end
            check_count++;
            if (o_read_done !== (c >= 2)) begin
                report_mismatch($sformatf("o_read_done is %b in back-to-back cycle %0d",
                                          o_read_done, c));
            end
            if (c >= 2) begin
                for (int s = 0; s < NUM_RD_SLOTS; s++) begin
                    check_count++;
                    if (o_read_data[s] !== batch_data[c - 2][s]) begin
                        report_mismatch($sformatf("batch %0d slot %0d read %h, expected %h",
                                                  c - 2, s, o_read_data[s],
                                                  batch_data[c - 2][s]));
                    end
                end
            end
        end
        for (int s = 0; s < NUM_RD_SLOTS; s++) begin
            exp_slot[s] = batch_data[$size(batch_data) - 1][s];
        end
        exp_known = '1;
    endtask

    initial begin
        clk           = 1'b0;
        reset         = 1'b1;
        rng_state     = 32'd78;
        wait_limit    = 20;
        check_count   = 0;
        error_count   = 0;
        next_free_reg = 0;
        written_regs  = 0;
        exp_known     = '0;
        drive_idle();

        check_reset();
        write_and_read_back();
        mixed_batches();
        partial_and_empty();
        stalled_batches();
        back_to_back_reads();

        $display("checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

/* compile.f */
+incdir+include
src/regread_pkg.sv
src/bank_port_if.sv
src/port_picker.sv
src/port_scheduler.sv
src/banked_reg_file.sv
src/read_collector.sv
src/reg_read_stage.sv
tests/tb_reg_read_stage.sv

/* Bender.yml */
package:
  name: reg_read_stage

sources:
  - files:
      - src/regread_pkg.sv
      - src/bank_port_if.sv
      - src/port_picker.sv
      - src/port_scheduler.sv
      - src/banked_reg_file.sv
      - src/read_collector.sv
      - src/reg_read_stage.sv
  - target: test
    include_dirs:
      - include
    files:
      - tests/tb_reg_read_stage.sv
